// ==== nebula_stimulus.txt ====
# port op addr data sel expect, numbers in hex; op is wr, rd, tie or pad
# tie: data is the host word and expect the project word; pad: expect is the team select
host pad 0 0 0 0
host wr 30000000 deadbeef f 0
host rd 30000000 0 f deadbeef
project wr 30000004 12345678 f 0
project rd 30000004 0 f 12345678
host wr 30000008 11223344 f 0
host wr 30000008 aabbccdd 5 0
host rd 30000008 0 f 11bb33dd
project wr 30000008 00ee0000 4 0
project rd 30000008 0 f 11ee33dd
both tie 30000010 aaaa0001 f 55550002
host rd 30000010 0 f 55550002
both tie 30000010 aaaa0003 f 55550004
project rd 30000010 0 f aaaa0003
host wr 31000000 2 1 0
host pad 0 0 0 2
host rd 31000000 0 f 2
project wr 31000000 3 1 0
host pad 0 0 0 3
host wr 31000000 4 1 0
host pad 0 0 0 4
host wr 31000000 7 1 0
host pad 0 0 0 7
project rd 31000000 0 f 7
host wr 31000000 1 1 0
host pad 0 0 0 1
host wr 20000010 cafef00d f 0
host rd 20000010 0 f 0
project rd 40000000 0 f 0
host rd 30000010 0 f aaaa0003
host rd 30000000 0 f deadbeef

// ==== filelist.f ====
nebula_pkg.sv
wb_if.sv
wb_arbiter.sv
wb_decoder.sv
wb_sram.sv
gpio_control.sv
nebula_top.sv
tb_nebula.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Nebula testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ns --top-module tb_nebula \
    -f filelist.f -o tb_nebula
./obj_dir/tb_nebula | tee sim.log
grep -q "Testbench passed" sim.log

// ==== tb_nebula.sv ====
//////////////////////////////////////////////////
// Testbench for the Nebula interconnect, both
// managers driven from a stimulus file
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_nebula import nebula_pkg::*; ();

    localparam int MAX_OPS = 64;

    logic              wb_clk_i;
    logic              rst_n_i;
    logic              wbs_cyc_i;
    logic              wbs_stb_i;
    logic              wbs_we_i;
    logic [SEL_W-1:0]  wbs_sel_i;
    logic [ADDR_W-1:0] wbs_adr_i;
    logic [DATA_W-1:0] wbs_dat_i;
    logic              wbs_ack_o;
    logic [DATA_W-1:0] wbs_dat_o;
    logic              proj_cyc_i;
    logic              proj_stb_i;
    logic              proj_we_i;
    logic [SEL_W-1:0]  proj_sel_i;
    logic [ADDR_W-1:0] proj_adr_i;
    logic [DATA_W-1:0] proj_dat_i;
    logic              proj_ack_o;
    logic [DATA_W-1:0] proj_dat_o;
    team_gpio_t        designs_gpio_out_i;
    team_gpio_t        designs_gpio_oeb_i;
    gpio_vec_t         io_out_o;
    gpio_vec_t         io_oeb_o;

    int cycles = 0;
    int cycle_limit;
    int host_acks = 0;
    int proj_acks = 0;

    // Operations loaded from the stimulus file
    bit                use_host_q [MAX_OPS];
    bit                use_proj_q [MAX_OPS];
    logic [63:0]       op_q       [MAX_OPS];
    logic [ADDR_W-1:0] adr_q      [MAX_OPS];
    logic [DATA_W-1:0] dat_q      [MAX_OPS];
    logic [SEL_W-1:0]  sel_q      [MAX_OPS];
    logic [DATA_W-1:0] exp_q      [MAX_OPS];

    nebula_top uut (.*);

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERR %s actual=%h expected=%h", name, actual, expected);
            abort_run();
        end
    endtask

    // Ack pulses per manager, counted mid-cycle
    always @(negedge wb_clk_i) begin
        if (wbs_ack_o) host_acks++;
        if (proj_ack_o) proj_acks++;
    end

    always @(posedge wb_clk_i) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            abort_run();
        end
    end

    // One transfer per selected manager, each released after its own ack
    task automatic run_bus_op(input int i, output int host_edges, output int proj_edges,
                              output logic [DATA_W-1:0] host_rd,
                              output logic [DATA_W-1:0] proj_rd);
        int edges;
        bit host_done;
        bit proj_done;
        wbs_we_i   = (op_q[i] != "rd");
        wbs_adr_i  = adr_q[i];
        wbs_sel_i  = sel_q[i];
        wbs_dat_i  = dat_q[i];
        wbs_cyc_i  = use_host_q[i];
        wbs_stb_i  = use_host_q[i];
        proj_we_i  = (op_q[i] != "rd");
        proj_adr_i = adr_q[i];
        proj_sel_i = sel_q[i];
        proj_dat_i = (op_q[i] == "tie") ? exp_q[i] : dat_q[i];  // Tie writes two words
        proj_cyc_i = use_proj_q[i];
        proj_stb_i = use_proj_q[i];
        edges      = 0;
        host_edges = 0;
        proj_edges = 0;
        host_rd    = '0;
        proj_rd    = '0;
        host_done  = !use_host_q[i];
        proj_done  = !use_proj_q[i];
        while (!(host_done && proj_done)) begin
            @(posedge wb_clk_i);
            edges++;
            #1;
            if (host_done) begin
                wbs_cyc_i = 1'b0;
                wbs_stb_i = 1'b0;
            end
            if (proj_done) begin
                proj_cyc_i = 1'b0;
                proj_stb_i = 1'b0;
            end
            @(negedge wb_clk_i);
            if (!host_done && wbs_ack_o) begin
                host_done  = 1'b1;
                host_edges = edges;
                host_rd    = wbs_dat_o;
            end
            if (!proj_done && proj_ack_o) begin
                proj_done  = 1'b1;
                proj_edges = edges;
                proj_rd    = proj_dat_o;
            end
        end
        @(posedge wb_clk_i);
        #1;
        wbs_cyc_i  = 1'b0;
        wbs_stb_i  = 1'b0;
        proj_cyc_i = 1'b0;
        proj_stb_i = 1'b0;
        @(posedge wb_clk_i);  // Idle cycle between transfers
        #1;
    endtask

    initial begin
        int                fd;
        int                rc;
        int                n_ops;
        int                base_h;
        int                base_p;
        int                host_edges;
        int                proj_edges;
        int                team;
        logic [63:0]       tok;
        logic [8*128-1:0]  line;
        logic [31:0]       lcg_state;
        logic [31:0]       hi_draw;
        logic [DATA_W-1:0] host_rd;
        logic [DATA_W-1:0] proj_rd;
        gpio_vec_t         exp_out;
        gpio_vec_t         exp_oeb;
        rst_n_i    = 1'b0;
        wbs_cyc_i  = 1'b0;
        wbs_stb_i  = 1'b0;
        wbs_we_i   = 1'b0;
        wbs_sel_i  = '0;
        wbs_adr_i  = '0;
        wbs_dat_i  = '0;
        proj_cyc_i = 1'b0;
        proj_stb_i = 1'b0;
        proj_we_i  = 1'b0;
        proj_sel_i = '0;
        proj_adr_i = '0;
        proj_dat_i = '0;
        lcg_state  = 32'h131b;
        for (int t = 0; t < NUM_TEAMS; t++) begin
            lcg_state = lcg_next(lcg_state);
            hi_draw   = lcg_state;
            lcg_state = lcg_next(lcg_state);
            designs_gpio_out_i[t] = {hi_draw[21:16], lcg_state};
            lcg_state = lcg_next(lcg_state);
            hi_draw   = lcg_state;
            lcg_state = lcg_next(lcg_state);
            designs_gpio_oeb_i[t] = {hi_draw[21:16], lcg_state};
        end

        fd = $fopen("nebula_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file nebula_stimulus.txt");
            abort_run();
        end
        n_ops = 0;
        rc    = $fscanf(fd, "%s", tok);
        while (rc == 1) begin
            if (tok == "#") begin
                rc = $fgets(line, fd);  // Comment line
            end else begin
                use_host_q[n_ops] = (tok == "host") || (tok == "both");
                use_proj_q[n_ops] = (tok == "project") || (tok == "both");
                rc = $fscanf(fd, "%s %h %h %h %h", op_q[n_ops], adr_q[n_ops],
                             dat_q[n_ops], sel_q[n_ops], exp_q[n_ops]);
                if (rc != 5 || !(use_host_q[n_ops] || use_proj_q[n_ops])) begin
                    $display("Stimulus line %0d is malformed", n_ops + 1);
                    abort_run();
                end
                n_ops++;
            end
            rc = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
        cycle_limit = 20 * n_ops + 100;

        repeat (16) @(posedge wb_clk_i);
        #1;
        rst_n_i = 1'b1;
        @(negedge wb_clk_i);
        check_val("wbs_ack_o", 64'(wbs_ack_o), 64'd0);
        check_val("proj_ack_o", 64'(proj_ack_o), 64'd0);
        @(posedge wb_clk_i);
        #1;

        for (int i = 0; i < n_ops; i++) begin
            if (op_q[i] == "pad") begin
                team    = int'(exp_q[i]);
                exp_out = '0;
                exp_oeb = '1;  // Out of range select parks the pads
                if (team < NUM_TEAMS) begin
                    exp_out = designs_gpio_out_i[team];
                    exp_oeb = designs_gpio_oeb_i[team];
                end
                @(negedge wb_clk_i);
                check_val("io_out_o", 64'(io_out_o), 64'(exp_out));
                check_val("io_oeb_o", 64'(io_oeb_o), 64'(exp_oeb));
                @(posedge wb_clk_i);
                #1;
            end else begin
                base_h = host_acks;
                base_p = proj_acks;
                run_bus_op(i, host_edges, proj_edges, host_rd, proj_rd);
                check_val("wbs_ack_o count", 64'(host_acks - base_h), 64'(use_host_q[i]));
                check_val("proj_ack_o count", 64'(proj_acks - base_p), 64'(use_proj_q[i]));
                if (op_q[i] == "tie") begin
                    // Winner of the tie sees the plain two-edge latency
                    team = (host_edges < proj_edges) ? host_edges : proj_edges;
                    check_val("tie winner ack latency", 64'(team), 64'd2);
                end else begin
                    team = use_host_q[i] ? host_edges : proj_edges;
                    check_val("ack latency", 64'(team), 64'd2);
                end
                if (op_q[i] == "rd" && use_host_q[i]) begin
                    check_val("wbs_dat_o", 64'(host_rd), 64'(exp_q[i]));
                end
                if (op_q[i] == "rd" && use_proj_q[i]) begin
                    check_val("proj_dat_o", 64'(proj_rd), 64'(exp_q[i]));
                end
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== nebula_top.sv ====
//////////////////////////////////////////////////
// Nebula interconnect top level
// Arbiter, decoder, SRAM and pad select
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module nebula_top import nebula_pkg::*; (
    input  logic              wb_clk_i,
    input  logic              rst_n_i,

    // Host manager port
    input  logic              wbs_cyc_i,
    input  logic              wbs_stb_i,
    input  logic              wbs_we_i,
    input  logic [SEL_W-1:0]  wbs_sel_i,
    input  logic [ADDR_W-1:0] wbs_adr_i,
    input  logic [DATA_W-1:0] wbs_dat_i,
    output logic              wbs_ack_o,
    output logic [DATA_W-1:0] wbs_dat_o,

    // Project manager port
    input  logic              proj_cyc_i,
    input  logic              proj_stb_i,
    input  logic              proj_we_i,
    input  logic [SEL_W-1:0]  proj_sel_i,
    input  logic [ADDR_W-1:0] proj_adr_i,
    input  logic [DATA_W-1:0] proj_dat_i,
    output logic              proj_ack_o,
    output logic [DATA_W-1:0] proj_dat_o,

    // Pads
    input  team_gpio_t        designs_gpio_out_i,
    input  team_gpio_t        designs_gpio_oeb_i,
    output gpio_vec_t         io_out_o,
    output gpio_vec_t         io_oeb_o
);

    wb_if bus_host ();
    wb_if bus_proj ();
    wb_if bus_shared ();
    wb_if bus_sram ();
    wb_if bus_gpio ();

    // Host port onto its bus
    assign bus_host.cyc   = wbs_cyc_i;
    assign bus_host.stb   = wbs_stb_i;
    assign bus_host.we    = wbs_we_i;
    assign bus_host.sel   = wbs_sel_i;
    assign bus_host.adr   = wbs_adr_i;
    assign bus_host.dat_w = wbs_dat_i;
    assign wbs_ack_o      = bus_host.ack;
    assign wbs_dat_o      = bus_host.dat_r;

    // Project manager port
    assign bus_proj.cyc   = proj_cyc_i;
    assign bus_proj.stb   = proj_stb_i;
    assign bus_proj.we    = proj_we_i;
    assign bus_proj.sel   = proj_sel_i;
    assign bus_proj.adr   = proj_adr_i;
    assign bus_proj.dat_w = proj_dat_i;
    assign proj_ack_o     = bus_proj.ack;
    assign proj_dat_o     = bus_proj.dat_r;

    wb_arbiter u_arbiter (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .host_i   (bus_host),
        .proj_i   (bus_proj),
        .shared_o (bus_shared)
    );

    wb_decoder u_decoder (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .shared_i (bus_shared),
        .sram_o   (bus_sram),
        .gpio_o   (bus_gpio)
    );

    wb_sram u_sram (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .bus_i    (bus_sram)
    );

    gpio_control u_gpio_control (
        .wb_clk_i           (wb_clk_i),
        .rst_n_i            (rst_n_i),
        .bus_i              (bus_gpio),
        .designs_gpio_out_i (designs_gpio_out_i),
        .designs_gpio_oeb_i (designs_gpio_oeb_i),
        .io_out_o           (io_out_o),
        .io_oeb_o           (io_oeb_o)
    );

endmodule

`default_nettype wire

// ==== gpio_control.sv ====
//////////////////////////////////////////////////
// Team-select register that steers one team's
// outputs and enables onto the shared pads
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module gpio_control import nebula_pkg::*; (
    input  logic       wb_clk_i,
    input  logic       rst_n_i,
    wb_if.sub          bus_i,
    input  team_gpio_t designs_gpio_out_i,
    input  team_gpio_t designs_gpio_oeb_i,  // Active low enables
    output gpio_vec_t  io_out_o,
    output gpio_vec_t  io_oeb_o
);

    logic [TEAM_SEL_W-1:0] team_sel_q;
    logic [TEAM_IDX_W-1:0] team_idx;
    logic                  team_valid;
    logic                  ack_q;
    logic                  access;

    assign access = bus_i.cyc & bus_i.stb & ~ack_q;

    // Register lives in byte 0
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            team_sel_q <= '0;  // Team 0 owns the pads
            ack_q      <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && bus_i.we && bus_i.sel[0]) begin
                team_sel_q <= bus_i.dat_w[TEAM_SEL_W-1:0];
            end
        end
    end

    assign bus_i.ack   = ack_q;
    assign bus_i.dat_r = DATA_W'(team_sel_q);

    assign team_idx   = team_sel_q[TEAM_IDX_W-1:0];
    assign team_valid = (team_sel_q < TEAM_SEL_W'(NUM_TEAMS));

    // Out-of-range select parks every pad as input
    always_comb begin
        if (team_valid) begin
            io_out_o = designs_gpio_out_i[team_idx];
            io_oeb_o = designs_gpio_oeb_i[team_idx];
        end else begin
            io_out_o = '0;
            io_oeb_o = '1;
        end
    end

endmodule

`default_nettype wire

// ==== wb_sram.sv ====
//////////////////////////////////////////////////
// Word SRAM on Wishbone with byte-select writes
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module wb_sram import nebula_pkg::*; (
    input  logic wb_clk_i,
    input  logic rst_n_i,
    wb_if.sub    bus_i
);

    logic [DATA_W-1:0]  mem_q [SRAM_WORDS];
    logic [DATA_W-1:0]  rd_data_q;
    logic [SRAM_AW-1:0] word_idx;
    logic               ack_q;
    logic               access;
    logic               wr_en;
    logic               rd_en;

    assign word_idx = bus_i.adr[SRAM_AW+1:2];  // Skip the byte bits

    // Accept once per transfer
    assign access = bus_i.cyc & bus_i.stb & ~ack_q;
    assign wr_en  = access & bus_i.we;
    assign rd_en  = access & ~bus_i.we;

    always_ff @(posedge wb_clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (bus_i.sel[b]) begin
                    mem_q[word_idx][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
                end
            end
        end
        if (rd_en) begin
            rd_data_q <= mem_q[word_idx];
        end
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign bus_i.ack   = ack_q;
    assign bus_i.dat_r = rd_data_q;  // Valid with ack on reads

endmodule

`default_nettype wire

// ==== wb_decoder.sv ====
//////////////////////////////////////////////////
// Address decoder for the shared bus, with an
// ack-and-zero responder for unmapped space
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module wb_decoder import nebula_pkg::*; (
    input  logic wb_clk_i,
    input  logic rst_n_i,
    wb_if.sub    shared_i,
    wb_if.mgr    sram_o,
    wb_if.mgr    gpio_o
);

    region_e region;
    logic    hit_sram;
    logic    hit_gpio;
    logic    none_ack_q;  // Unmapped responder
    logic    none_req;

    // Region from the top address byte
    always_comb begin
        if ((shared_i.adr & REGION_MASK) == (SRAM_BASE & REGION_MASK)) begin
            region = REGION_SRAM;
        end else if ((shared_i.adr & REGION_MASK) == (GPIO_BASE & REGION_MASK)) begin
            region = REGION_GPIO;
        end else begin
            region = REGION_NONE;
        end
    end

    assign hit_sram = (region == REGION_SRAM);
    assign hit_gpio = (region == REGION_GPIO);

    // SRAM leg
    assign sram_o.cyc   = shared_i.cyc & hit_sram;
    assign sram_o.stb   = shared_i.stb & hit_sram;
    assign sram_o.we    = shared_i.we;
    assign sram_o.adr   = shared_i.adr;
    assign sram_o.dat_w = shared_i.dat_w;
    assign sram_o.sel   = shared_i.sel;

    // GPIO control leg
    assign gpio_o.cyc   = shared_i.cyc & hit_gpio;
    assign gpio_o.stb   = shared_i.stb & hit_gpio;
    assign gpio_o.we    = shared_i.we;
    assign gpio_o.adr   = shared_i.adr;
    assign gpio_o.dat_w = shared_i.dat_w;
    assign gpio_o.sel   = shared_i.sel;

    assign none_req = shared_i.cyc & shared_i.stb & (region == REGION_NONE);

    // One-cycle pulse, writes are dropped
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= none_req & ~none_ack_q;
        end
    end

    // Response mux back to the arbiter
    always_comb begin
        case (region)
            REGION_SRAM: begin
                shared_i.ack   = sram_o.ack;
                shared_i.dat_r = sram_o.dat_r;
            end
            REGION_GPIO: begin
                shared_i.ack   = gpio_o.ack;
                shared_i.dat_r = gpio_o.dat_r;
            end
            default: begin
                shared_i.ack   = none_ack_q;
                shared_i.dat_r = '0;  // Unmapped reads return zero
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== wb_arbiter.sv ====
//////////////////////////////////////////////////
// Round-robin arbiter between host and project
// managers onto the shared Wishbone bus
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module wb_arbiter import nebula_pkg::*; (
    input  logic wb_clk_i,
    input  logic rst_n_i,
    wb_if.sub    host_i,
    wb_if.sub    proj_i,
    wb_if.mgr    shared_o
);

    arb_state_e state_q;
    arb_state_e state_d;
    logic       last_proj_q;  // Project had the bus last
    logic       last_proj_d;
    logic       host_req;
    logic       proj_req;
    logic       grant_host;
    logic       grant_proj;

    assign host_req = host_i.cyc & host_i.stb;
    assign proj_req = proj_i.cyc & proj_i.stb;

    // Grant decision, only taken from idle
    always_comb begin
        state_d     = state_q;
        last_proj_d = last_proj_q;
        case (state_q)
            ARB_IDLE: begin
                if (host_req && (!proj_req || last_proj_q)) begin
                    state_d     = ARB_HOST;
                    last_proj_d = 1'b0;
                end else if (proj_req) begin
                    state_d     = ARB_PROJ;
                    last_proj_d = 1'b1;
                end
            end
            ARB_HOST: begin
                if (!host_i.cyc) state_d = ARB_IDLE; // Cycle ended
            end
            ARB_PROJ: begin
                if (!proj_i.cyc) state_d = ARB_IDLE;
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= ARB_IDLE;
            last_proj_q <= 1'b1;  // Host wins the first tie
        end else begin
            state_q     <= state_d;
            last_proj_q <= last_proj_d;
        end
    end

    assign grant_host = (state_q == ARB_HOST);
    assign grant_proj = (state_q == ARB_PROJ);

    // Request path, strobes quiet while idle
    assign shared_o.cyc   = (grant_host & host_i.cyc) | (grant_proj & proj_i.cyc);
    assign shared_o.stb   = (grant_host & host_i.stb) | (grant_proj & proj_i.stb);
    assign shared_o.we    = grant_proj ? proj_i.we    : host_i.we;
    assign shared_o.adr   = grant_proj ? proj_i.adr   : host_i.adr;
    assign shared_o.dat_w = grant_proj ? proj_i.dat_w : host_i.dat_w;
    assign shared_o.sel   = grant_proj ? proj_i.sel   : host_i.sel;

    // Response goes back to the winner only
    assign host_i.ack   = grant_host & shared_o.ack;
    assign host_i.dat_r = grant_host ? shared_o.dat_r : '0;
    assign proj_i.ack   = grant_proj & shared_o.ack;
    assign proj_i.dat_r = grant_proj ? shared_o.dat_r : '0;

endmodule

`default_nettype wire

// ==== wb_if.sv ====
//////////////////////////////////////////////////
// Wishbone classic bus bundle
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface wb_if import nebula_pkg::*; ();

    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat_w;  // Manager to subordinate
    logic [SEL_W-1:0]  sel;
    logic [DATA_W-1:0] dat_r;  // Subordinate to manager
    logic              ack;

    // Bus manager side
    modport mgr (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    // Bus subordinate side
    modport sub (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );

endinterface

`default_nettype wire

// ==== nebula_pkg.sv ====
//////////////////////////////////////////////////
// Nebula shared definitions
// Bus widths, address map, team count and enums
//////////////////////////////////////////////////
`default_nettype none

package nebula_pkg;

    // Wishbone bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    // Pads and teams
    localparam int GPIO_W     = 38;
    localparam int NUM_TEAMS  = 4;
    localparam int TEAM_SEL_W = 3;                 // Holds values past NUM_TEAMS
    localparam int TEAM_IDX_W = $clog2(NUM_TEAMS); // Index into the team array

    // SRAM geometry
    localparam int SRAM_WORDS = 256;
    localparam int SRAM_AW    = 8;

    // Address map, region picked by the top byte
    localparam logic [ADDR_W-1:0] SRAM_BASE   = 32'h3000_0000;
    localparam logic [ADDR_W-1:0] GPIO_BASE   = 32'h3100_0000;
    localparam logic [ADDR_W-1:0] REGION_MASK = 32'hFF00_0000;

    // Arbiter grant state
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_HOST,
        ARB_PROJ
    } arb_state_e;

    // Decoder target
    typedef enum logic [1:0] {
        REGION_SRAM,
        REGION_GPIO,
        REGION_NONE
    } region_e;

    typedef logic [GPIO_W-1:0] gpio_vec_t;
    typedef gpio_vec_t [NUM_TEAMS-1:0] team_gpio_t; // One pad vector per team

endpackage

`default_nettype wire
